// File: design/mvm_pkg.sv
// Sizes, element types and control buses shared by the matrix-vector multiplier blocks.
`default_nettype none

package mvm_pkg;

	localparam int ROWS   = 16;  // matrix rows, one multiply-accumulate lane each.
	localparam int COLS   = 16;  // matrix columns and vector length.
	localparam int DATA_W = 8;
	localparam int ACC_W  = 16;  // results wrap modulo 2**ACC_W.
	localparam int COL_AW = $clog2(COLS);
	localparam int ROW_AW = $clog2(ROWS);

	typedef logic signed [DATA_W-1:0] elem_t;
	typedef logic signed [ACC_W-1:0]  acc_t;
	typedef logic [COL_AW-1:0]        col_addr_t;
	typedef logic [ROW_AW-1:0]        row_addr_t;

	localparam col_addr_t LAST_COL = col_addr_t'(COLS - 1);
	localparam row_addr_t LAST_ROW = row_addr_t'(ROWS - 1);

	// Matrix load bus, fanned out to every row bank.
	typedef struct packed {
		logic [ROWS-1:0] en;    // one-hot, bit r writes row bank r.
		col_addr_t       addr;  // column being written.
	} matrix_wr_t;

	typedef struct packed {
		logic      clear;       // zero all accumulators.
		logic      accumulate;  // add the product of the words read last cycle.
		col_addr_t addr;        // column read address for rows and vector.
	} mac_ctrl_t;

	typedef struct packed {
		logic      wr;    // store acc[addr] at addr.
		logic      rd;    // read addr, word shows up one cycle later.
		row_addr_t addr;
	} result_ctrl_t;

endpackage

`default_nettype wire

// File: design/word_ram.sv
// Single-port synchronous RAM with a registered read-first output, used for the vector and results.
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
	parameter int WIDTH = 8
) (
	input  logic               clk,
	input  logic               wr_en,
	input  mvm_pkg::col_addr_t addr,
	input  logic [WIDTH-1:0]   wdata,
	output logic [WIDTH-1:0]   rdata
);

	logic [WIDTH-1:0] mem [mvm_pkg::COLS];

	always_ff @(posedge clk) begin
		rdata <= mem[addr];  // old contents come out on a write cycle.
		if (wr_en) begin
			mem[addr] <= wdata;
		end
	end

	// An unknown address would corrupt an unknown word.
	assert property (@(posedge clk) wr_en |-> !$isunknown(addr))
		else $error("word_ram write with unknown address");

endmodule

`default_nettype wire

// File: design/mac_row.sv
// One matrix row bank with its multiply-accumulate lane, instantiated once per row by the top level.
`timescale 1ns/1ps
`default_nettype none

module mac_row (
	input  logic               clk,
	input  logic               wr_en,
	input  mvm_pkg::col_addr_t wr_addr,
	input  mvm_pkg::elem_t     data_in,
	input  mvm_pkg::mac_ctrl_t ctrl,
	input  mvm_pkg::elem_t     x_elem,
	output mvm_pkg::acc_t      acc
);

	mvm_pkg::elem_t     row_mem [mvm_pkg::COLS];
	mvm_pkg::col_addr_t addr;
	mvm_pkg::elem_t     row_elem;
	mvm_pkg::acc_t      product;

	// The bank has a single port, so loading and computing share the address.
	assign addr = wr_en ? wr_addr : ctrl.addr;

	always_ff @(posedge clk) begin
		row_elem <= row_mem[addr];  // lines up with the registered vector word.
		if (wr_en) begin
			row_mem[addr] <= data_in;
		end
	end

	// Both factors are sign-extended first so the product is exact in ACC_W bits.
	assign product = mvm_pkg::acc_t'(row_elem) * mvm_pkg::acc_t'(x_elem);

	always_ff @(posedge clk) begin
		if (ctrl.clear) begin
			acc <= '0;
		end else if (ctrl.accumulate) begin
			acc <= acc + product;  // wraps modulo 2**ACC_W.
		end
	end

endmodule

`default_nettype wire

// File: design/result_store.sv
// Result memory that captures one accumulator per row and streams the stored results back out.
`timescale 1ns/1ps
`default_nettype none

module result_store (
	input  logic                  clk,
	input  mvm_pkg::result_ctrl_t ctrl,
	input  mvm_pkg::acc_t         acc [mvm_pkg::ROWS],
	output mvm_pkg::acc_t         data_out
);

	mvm_pkg::acc_t            wdata;
	logic [mvm_pkg::ACC_W-1:0] rdata;
	logic                     rd_q;
	mvm_pkg::acc_t            held;

	// Row-indexed mux over all lanes.
	assign wdata = acc[ctrl.addr];

	word_ram #(
		.WIDTH(mvm_pkg::ACC_W)
	) y_ram_i (
		.clk  (clk),
		.wr_en(ctrl.wr),
		.addr (ctrl.addr),
		.wdata(wdata),
		.rdata(rdata)
	);

	always_ff @(posedge clk) begin
		rd_q <= ctrl.rd;  // marks the cycle the read word is valid.
		if (rd_q) begin
			held <= rdata;
		end
	end

	// The last streamed result stays on data_out until the next readout.
	assign data_out = rd_q ? mvm_pkg::acc_t'(rdata) : held;

	// The sequencer never writes back and reads out in the same cycle.
	assert property (@(posedge clk) ctrl.wr |-> !ctrl.rd)
		else $error("result RAM write and read in the same cycle");

endmodule

`default_nettype wire

// File: design/mvm_sequencer.sv
// Control FSM with the column and row counters that drive load, compute, writeback and readout.
`timescale 1ns/1ps
`default_nettype none

module mvm_sequencer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  load_matrix,
	input  logic                  load_vector,
	input  logic                  start,
	output mvm_pkg::matrix_wr_t   matrix_wr,
	output logic                  vec_wr_en,
	output mvm_pkg::col_addr_t    vec_addr,
	output mvm_pkg::mac_ctrl_t    mac_ctrl,
	output mvm_pkg::result_ctrl_t result_ctrl,
	output logic                  done
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_MLOAD,
		S_VLOAD,
		S_CLEAR,
		S_ACCUM,
		S_WRITEBACK,
		S_READOUT
	} state_t;

	state_t             state;
	state_t             next_state;
	mvm_pkg::col_addr_t col_cnt;
	mvm_pkg::row_addr_t row_cnt;
	logic               acc_dly;
	logic               last_col;
	logic               last_row;
	logic               wb_write;

	assign last_col = (col_cnt == mvm_pkg::LAST_COL);
	assign last_row = (row_cnt == mvm_pkg::LAST_ROW);

	// The first writeback cycle waits for the final accumulate to land.
	assign wb_write = (state == S_WRITEBACK) && !acc_dly;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				if (start) begin  // start wins over both loads.
					next_state = S_CLEAR;
				end else if (load_matrix) begin
					next_state = S_MLOAD;
				end else if (load_vector) begin
					next_state = S_VLOAD;
				end
			end
			S_MLOAD: begin
				if (last_col && last_row) begin
					next_state = S_IDLE;
				end
			end
			S_VLOAD: begin
				if (last_col) begin
					next_state = S_IDLE;
				end
			end
			S_CLEAR: begin
				next_state = S_ACCUM;
			end
			S_ACCUM: begin
				if (last_col) begin
					next_state = S_WRITEBACK;
				end
			end
			S_WRITEBACK: begin
				if (wb_write && last_row) begin
					next_state = S_READOUT;
				end
			end
			S_READOUT: begin
				if (last_row) begin
					next_state = S_IDLE;
				end
			end
			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

	// Column counter wraps back to zero at the end of every pass.
	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt <= '0;
		end else if (state == S_MLOAD || state == S_VLOAD || state == S_ACCUM) begin
			col_cnt <= col_cnt + mvm_pkg::col_addr_t'(1);
		end else begin
			col_cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			row_cnt <= '0;
		end else begin
			case (state)
				S_MLOAD: begin
					if (last_col) begin
						row_cnt <= row_cnt + mvm_pkg::row_addr_t'(1);  // next bank.
					end
				end
				S_WRITEBACK: begin
					if (wb_write) begin
						row_cnt <= row_cnt + mvm_pkg::row_addr_t'(1);
					end
				end
				S_READOUT: begin
					row_cnt <= row_cnt + mvm_pkg::row_addr_t'(1);
				end
				default: begin
					row_cnt <= '0;
				end
			endcase
		end
	end

	// Accumulate trails each column address by the RAM read latency.
	always_ff @(posedge clk) begin
		if (reset) begin
			acc_dly <= 1'b0;
		end else begin
			acc_dly <= (state == S_ACCUM);
		end
	end

	always_comb begin
		matrix_wr.en = '0;
		if (state == S_MLOAD) begin
			matrix_wr.en[row_cnt] = 1'b1;
		end
		matrix_wr.addr = col_cnt;
	end

	assign vec_wr_en = (state == S_VLOAD);
	assign vec_addr  = col_cnt;  // same counter as mac_ctrl.addr during compute.

	assign mac_ctrl.clear      = (state == S_CLEAR);
	assign mac_ctrl.accumulate = acc_dly;
	assign mac_ctrl.addr       = col_cnt;

	assign result_ctrl.wr   = wb_write;
	assign result_ctrl.rd   = (state == S_READOUT);
	assign result_ctrl.addr = row_cnt;

	// y[0] appears on data_out the cycle after this.
	assign done = (state == S_READOUT) && (row_cnt == '0);

	assert property (@(posedge clk) disable iff (reset) $onehot0(matrix_wr.en))
		else $error("more than one matrix row bank enabled");

endmodule

`default_nettype wire

// File: design/mvm_top.sv
// Top level of the signed matrix-vector multiplier, connecting sequencer, vector RAM, lanes and results.
`timescale 1ns/1ps
`default_nettype none

module mvm_top (
	input  logic           clk,
	input  logic           reset,
	input  logic           load_matrix,
	input  logic           load_vector,
	input  logic           start,
	input  mvm_pkg::elem_t data_in,
	output logic           done,
	output mvm_pkg::acc_t  data_out
);

	mvm_pkg::matrix_wr_t   matrix_wr;
	logic                  vec_wr_en;
	mvm_pkg::col_addr_t    vec_addr;
	mvm_pkg::mac_ctrl_t    mac_ctrl;
	mvm_pkg::result_ctrl_t result_ctrl;
	mvm_pkg::elem_t        x_elem;
	mvm_pkg::acc_t         acc [mvm_pkg::ROWS];

	mvm_sequencer seq_i (
		.clk        (clk),
		.reset      (reset),
		.load_matrix(load_matrix),
		.load_vector(load_vector),
		.start      (start),
		.matrix_wr  (matrix_wr),
		.vec_wr_en  (vec_wr_en),
		.vec_addr   (vec_addr),
		.mac_ctrl   (mac_ctrl),
		.result_ctrl(result_ctrl),
		.done       (done)
	);

	// x is read once per column and broadcast to every lane.
	word_ram #(
		.WIDTH(mvm_pkg::DATA_W)
	) vec_ram_i (
		.clk  (clk),
		.wr_en(vec_wr_en),
		.addr (vec_addr),
		.wdata(data_in),
		.rdata(x_elem)
	);

	for (genvar r = 0; r < mvm_pkg::ROWS; r++) begin : g_row
		mac_row row_i (
			.clk    (clk),
			.wr_en  (matrix_wr.en[r]),
			.wr_addr(matrix_wr.addr),
			.data_in(data_in),
			.ctrl   (mac_ctrl),
			.x_elem (x_elem),
			.acc    (acc[r])
		);
	end

	result_store res_i (
		.clk     (clk),
		.ctrl    (result_ctrl),
		.acc     (acc),
		.data_out(data_out)
	);

endmodule

`default_nettype wire

// File: sim/mvm_tb.sv
// Directed testbench for mvm_top that loads matrices and vectors and checks y against a model.
`timescale 1ns/1ps
`default_nettype none

module mvm_tb;

	localparam int CLK_HALF   = 50;
	localparam int MAX_CYCLES = 3000;  // covers four matrix loads and six runs with margin.

	logic           clk;
	logic           reset;
	logic           load_matrix;
	logic           load_vector;
	logic           start;
	mvm_pkg::elem_t data_in;
	logic           done;
	mvm_pkg::acc_t  data_out;

	mvm_pkg::elem_t a_model [mvm_pkg::ROWS][mvm_pkg::COLS];
	mvm_pkg::elem_t x_model [mvm_pkg::COLS];
	mvm_pkg::acc_t  y_got   [mvm_pkg::ROWS];
	integer         seed;
	int             cycle_count = 0;

	mvm_top dut_i (
		.clk        (clk),
		.reset      (reset),
		.load_matrix(load_matrix),
		.load_vector(load_vector),
		.start      (start),
		.data_in    (data_in),
		.done       (done),
		.data_out   (data_out)
	);

	initial begin
		clk = 1'b0;
	end

	always #CLK_HALF clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Test failed");
			$fatal(1, "timeout, the run did not finish within %0d cycles", MAX_CYCLES);
		end
	end

	task automatic check_acc(input string name, input mvm_pkg::acc_t got,
			input mvm_pkg::acc_t expected);
		if (got !== expected) begin
			$display("FAIL at %0t: %s got %0d expected %0d", $time, name, got, expected);
			$display("Test failed");
			$fatal(1, "result mismatch on %s", name);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("FAIL at %0t: %s got %b expected %b", $time, name, got, expected);
			$display("Test failed");
			$fatal(1, "control mismatch on %s", name);
		end
	endtask

	// y[r] is the sum of A[r][c]*x[c], kept to the low ACC_W bits.
	function automatic mvm_pkg::acc_t model_y(input int r);
		int sum;
		sum = 0;
		for (int c = 0; c < mvm_pkg::COLS; c++) begin
			sum = sum + int'(a_model[r][c]) * int'(x_model[c]);
		end
		return mvm_pkg::acc_t'(sum);
	endfunction

	task automatic load_matrix_task();
		@(negedge clk);
		load_matrix = 1'b1;
		for (int r = 0; r < mvm_pkg::ROWS; r++) begin
			for (int c = 0; c < mvm_pkg::COLS; c++) begin
				@(negedge clk);
				load_matrix = 1'b0;
				data_in     = a_model[r][c];  // elements go in row-major order.
			end
		end
		@(negedge clk);
		data_in = '0;
	endtask

	task automatic load_vector_task();
		@(negedge clk);
		load_vector = 1'b1;
		for (int c = 0; c < mvm_pkg::COLS; c++) begin
			@(negedge clk);
			load_vector = 1'b0;
			data_in     = x_model[c];
		end
		@(negedge clk);
		data_in = '0;
	endtask

	// Pulses start, waits for done and captures the 16 streamed results.
	task automatic run_and_collect();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (done !== 1'b1) begin
			@(negedge clk);
		end
		for (int i = 0; i < mvm_pkg::ROWS; i++) begin
			@(negedge clk);
			y_got[i] = data_out;
			if (i == 0) begin
				check_bit("done", done, 1'b0);  // done lasts a single cycle.
			end
		end
	endtask

	task automatic check_against_model();
		for (int r = 0; r < mvm_pkg::ROWS; r++) begin
			check_acc($sformatf("y[%0d]", r), y_got[r], model_y(r));
		end
	endtask

	task automatic test_idle_after_reset();
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_bit("done", done, 1'b0);
		end
	endtask

	task automatic test_identity();
		for (int r = 0; r < mvm_pkg::ROWS; r++) begin
			for (int c = 0; c < mvm_pkg::COLS; c++) begin
				a_model[r][c] = (r == c) ? mvm_pkg::elem_t'(1) : mvm_pkg::elem_t'(0);
			end
		end
		for (int c = 0; c < mvm_pkg::COLS; c++) begin
			x_model[c] = mvm_pkg::elem_t'($random(seed));
		end
		load_matrix_task();
		load_vector_task();
		run_and_collect();
		for (int r = 0; r < mvm_pkg::ROWS; r++) begin
			check_acc($sformatf("y[%0d]", r), y_got[r], mvm_pkg::acc_t'(x_model[r]));
		end
	endtask

	task automatic test_extremes();
		for (int r = 0; r < mvm_pkg::ROWS; r++) begin
			for (int c = 0; c < mvm_pkg::COLS; c++) begin
				a_model[r][c] = mvm_pkg::elem_t'(-128);
			end
		end
		for (int c = 0; c < mvm_pkg::COLS; c++) begin
			x_model[c] = mvm_pkg::elem_t'(-128);
		end
		load_matrix_task();
		load_vector_task();
		run_and_collect();
		for (int r = 0; r < mvm_pkg::ROWS; r++) begin
			check_acc($sformatf("y[%0d]", r), y_got[r], mvm_pkg::acc_t'(0));  // 16*16384 wraps.
		end
		for (int r = 0; r < mvm_pkg::ROWS; r++) begin
			for (int c = 0; c < mvm_pkg::COLS; c++) begin
				a_model[r][c] = mvm_pkg::elem_t'(127);
			end
		end
		load_matrix_task();
		run_and_collect();
		for (int r = 0; r < mvm_pkg::ROWS; r++) begin
			check_acc($sformatf("y[%0d]", r), y_got[r],
				mvm_pkg::acc_t'(mvm_pkg::COLS * 127 * -128));
		end
	endtask

	task automatic test_random();
		for (int r = 0; r < mvm_pkg::ROWS; r++) begin
			for (int c = 0; c < mvm_pkg::COLS; c++) begin
				a_model[r][c] = mvm_pkg::elem_t'($random(seed));
			end
		end
		for (int c = 0; c < mvm_pkg::COLS; c++) begin
			x_model[c] = mvm_pkg::elem_t'($random(seed));
		end
		load_matrix_task();
		load_vector_task();
		run_and_collect();
		check_against_model();
	endtask

	// Only the vector changes, so the matrix banks still hold the random matrix.
	task automatic test_retained_matrix();
		for (int c = 0; c < mvm_pkg::COLS; c++) begin
			x_model[c] = mvm_pkg::elem_t'($random(seed));
		end
		load_vector_task();
		run_and_collect();
		check_against_model();
		run_and_collect();
		check_against_model();
	endtask

	initial begin
		seed        = 84;
		reset       = 1'b1;
		load_matrix = 1'b0;
		load_vector = 1'b0;
		start       = 1'b0;
		data_in     = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		test_idle_after_reset();
		test_identity();
		test_extremes();
		test_random();
		test_retained_matrix();

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
design/mvm_pkg.sv
design/word_ram.sv
design/mac_row.sv
design/result_store.sv
design/mvm_sequencer.sv
design/mvm_top.sv
sim/mvm_tb.sv

// File: run.sh
#!/bin/sh
# Builds the matrix-vector multiplier testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module mvm_tb \
	--Mdir obj_dir -o mvm_sim \
	-f sources.f

./obj_dir/mvm_sim
